//--- hdl/log_data_pkg.sv
package log_data_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths

  // Arguments, bases, moduli and results
  localparam int data_width = 16;

  // Vector length and element index
  localparam int count_width = 8;

  //////////////////////////////////////////////////////////////////////
  // Types

  // One data word
  typedef logic [data_width-1:0] data_t;

  // Element counter
  typedef logic [count_width-1:0] count_t;

  // Operands of a single element
  // Argument a, base b, modulus for the final reduction
  typedef struct packed {
    data_t argument;
    data_t base;
    data_t modulus;
  } log_operands_t;

endpackage

//--- hdl/log_ctrl_pkg.sv
package log_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sequencer

  // Waiting for start, gathering a pair, waiting on the core
  typedef enum logic [1:0] {
    seq_idle,
    seq_collect,
    seq_await
  } seq_state_t;

  //////////////////////////////////////////////////////////////////////
  // Logarithm core

  // Climb raises the power one step per cycle
  typedef enum logic [1:0] {
    core_idle,
    core_climb,
    core_reduce
  } core_state_t;

  //////////////////////////////////////////////////////////////////////
  // Modulo reducer

  // One subtraction per cycle in subtract
  typedef enum logic {
    red_idle,
    red_subtract
  } red_state_t;

endpackage

//--- hdl/modulo_reduce.sv
module modulo_reduce (
  input  logic                CLK,
  input  logic                RST,
  input  logic                red_start,
  input  log_data_pkg::data_t red_value,
  input  log_data_pkg::data_t red_modulo,
  output logic                red_done,
  output log_data_pkg::data_t red_result
);
  import log_data_pkg::*;
  import log_ctrl_pkg::*;

  red_state_t state;
  data_t      remainder;
  data_t      modulus;
  logic       keep_going;

  // Zero modulus means no reduction at all
  assign keep_going = (modulus != '0) && (remainder >= modulus);

  //////////////////////////////////////////////////////////////////////
  // Control

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= red_idle;
      red_done <= 1'b0;
    end else begin
      red_done <= 1'b0;
      case (state)
        red_idle: begin
          if (red_start) begin
            state <= red_subtract;
          end
        end
        red_subtract: begin
          // Remainder below modulus, finished
          if (!keep_going) begin
            red_done <= 1'b1;
            state    <= red_idle;
          end
        end
        default: state <= red_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath

  always_ff @(posedge CLK) begin
    if (state == red_idle && red_start) begin
      remainder <= red_value;
      modulus   <= red_modulo;
    end else if (state == red_subtract && keep_going) begin
      remainder <= remainder - modulus;
    end
  end

  // Holds the final remainder while idle
  assign red_result = remainder;

  // Core must keep the modulus stable until done
  assert property (@(posedge CLK) disable iff (RST)
    (red_done && red_modulo != '0) |-> (red_result < red_modulo))
  else $error("modulo_reduce: remainder %0d not below modulus %0d", red_result, red_modulo);

endmodule

//--- hdl/scalar_logarithm.sv
module scalar_logarithm (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        core_start,
  input  log_data_pkg::log_operands_t core_operands,
  output logic                        core_ready,
  output log_data_pkg::data_t         core_result
);
  import log_data_pkg::*;
  import log_ctrl_pkg::*;

  core_state_t             state;
  log_operands_t           ops;
  data_t                   power;
  data_t                   steps;
  logic [2*data_width-1:0] product;
  logic                    climb_on;
  logic                    trivial;

  // Reducer handshake
  logic  red_start;
  logic  red_done;
  data_t red_result;

  //////////////////////////////////////////////////////////////////////
  // Climb arithmetic

  // Next power at double width, never wraps
  assign product = {{data_width{1'b0}}, power} * {{data_width{1'b0}}, ops.base};

  // Another step fits under the argument
  assign climb_on = (product <= {{data_width{1'b0}}, ops.argument});

  // Zero argument or base 0/1 gives a logarithm of 0
  assign trivial = (core_operands.argument == '0) || (core_operands.base < data_t'(2));

  //////////////////////////////////////////////////////////////////////
  // Control

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= core_idle;
      core_ready <= 1'b0;
      red_start  <= 1'b0;
    end else begin
      core_ready <= 1'b0;
      red_start  <= 1'b0;
      case (state)
        core_idle: begin
          if (core_start) begin
            if (trivial) begin
              // Skip the climb, reduce a count of 0
              red_start <= 1'b1;
              state     <= core_reduce;
            end else begin
              state <= core_climb;
            end
          end
        end
        core_climb: begin
          // Overshoot, so steps is the floor logarithm
          if (!climb_on) begin
            red_start <= 1'b1;
            state     <= core_reduce;
          end
        end
        core_reduce: begin
          if (red_done) begin
            core_ready <= 1'b1;
            state      <= core_idle;
          end
        end
        default: state <= core_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath

  always_ff @(posedge CLK) begin
    if (state == core_idle && core_start) begin
      ops   <= core_operands;
      power <= data_t'(1);
      steps <= '0;
    end else if (state == core_climb && climb_on) begin
      // Power stays at or below the argument, low half is exact
      power <= product[data_width-1:0];
      steps <= steps + data_t'(1);
    end
    if (state == core_reduce && red_done) begin
      core_result <= red_result;
    end
  end

  modulo_reduce reducer (
    .CLK        (CLK),
    .RST        (RST),
    .red_start  (red_start),
    .red_value  (steps),
    .red_modulo (ops.modulus),
    .red_done   (red_done),
    .red_result (red_result)
  );

  // One result per start, never back to back
  assert property (@(posedge CLK) disable iff (RST) core_ready |=> !core_ready)
  else $error("scalar_logarithm: core_ready high two cycles in a row");

endmodule

//--- hdl/vector_logarithm.sv
module vector_logarithm (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  log_data_pkg::count_t        size_in,
  input  log_data_pkg::data_t         data_a_in,
  input  logic                        data_a_in_enable,
  input  log_data_pkg::data_t         data_b_in,
  input  logic                        data_b_in_enable,
  input  log_data_pkg::data_t         modulo_in,
  output log_data_pkg::data_t         data_out,
  output logic                        data_out_enable,
  output logic                        ready,
  output logic                        core_start,
  output log_data_pkg::log_operands_t core_operands,
  input  logic                        core_ready,
  input  log_data_pkg::data_t         core_result
);
  import log_data_pkg::*;
  import log_ctrl_pkg::*;

  seq_state_t state;
  count_t     size_q;
  count_t     index;
  logic       a_seen;
  logic       b_seen;
  logic       pair_done;
  logic       last_element;

  // Both operands present, this cycle or earlier
  assign pair_done = (state == seq_collect) &&
                     (a_seen || data_a_in_enable) &&
                     (b_seen || data_b_in_enable);

  // Only looked at with a nonzero size
  assign last_element = (index == size_q - count_t'(1));

  //////////////////////////////////////////////////////////////////////
  // Element sequencing

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= seq_idle;
      index           <= '0;
      a_seen          <= 1'b0;
      b_seen          <= 1'b0;
      core_start      <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
    end else begin
      // Pulses by default
      core_start      <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
      case (state)
        seq_idle: begin
          if (start) begin
            index  <= '0;
            a_seen <= 1'b0;
            b_seen <= 1'b0;
            // Empty vector finishes right away
            if (size_in == '0) begin
              ready <= 1'b1;
            end else begin
              state <= seq_collect;
            end
          end
        end
        seq_collect: begin
          if (pair_done) begin
            a_seen     <= 1'b0;
            b_seen     <= 1'b0;
            core_start <= 1'b1;
            state      <= seq_await;
          end else begin
            if (data_a_in_enable) begin
              a_seen <= 1'b1;
            end
            if (data_b_in_enable) begin
              b_seen <= 1'b1;
            end
          end
        end
        seq_await: begin
          // Inputs here are dropped
          if (core_ready) begin
            data_out_enable <= 1'b1;
            if (last_element) begin
              ready <= 1'b1;
              state <= seq_idle;
            end else begin
              index <= index + count_t'(1);
              state <= seq_collect;
            end
          end
        end
        default: state <= seq_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand and result capture

  always_ff @(posedge CLK) begin
    if (state == seq_idle && start) begin
      size_q <= size_in;
    end
    if (state == seq_collect) begin
      if (data_a_in_enable) begin
        core_operands.argument <= data_a_in;
      end
      if (data_b_in_enable) begin
        core_operands.base <= data_b_in;
      end
      // Modulus taken when the pair completes
      if (pair_done) begin
        core_operands.modulus <= modulo_in;
      end
    end
    if (state == seq_await && core_ready) begin
      data_out <= core_result;
    end
  end

  // Core kick only follows a completed pair
  assert property (@(posedge CLK) disable iff (RST)
    $rose(core_start) |-> ($past(state) == seq_collect))
  else $error("vector_logarithm: core_start raised outside collect");

endmodule

//--- hdl/log_unit_top.sv
module log_unit_top (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  log_data_pkg::count_t size_in,
  input  log_data_pkg::data_t  data_a_in,
  input  logic                 data_a_in_enable,
  input  log_data_pkg::data_t  data_b_in,
  input  logic                 data_b_in_enable,
  input  log_data_pkg::data_t  modulo_in,
  output log_data_pkg::data_t  data_out,
  output logic                 data_out_enable,
  output logic                 ready
);
  import log_data_pkg::*;

  // Sequencer to core
  logic          core_start;
  log_operands_t core_operands;

  // Core back to sequencer
  logic  core_ready;
  data_t core_result;

  vector_logarithm sequencer (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .size_in          (size_in),
    .data_a_in        (data_a_in),
    .data_a_in_enable (data_a_in_enable),
    .data_b_in        (data_b_in),
    .data_b_in_enable (data_b_in_enable),
    .modulo_in        (modulo_in),
    .data_out         (data_out),
    .data_out_enable  (data_out_enable),
    .ready            (ready),
    .core_start       (core_start),
    .core_operands    (core_operands),
    .core_ready       (core_ready),
    .core_result      (core_result)
  );

  scalar_logarithm core (
    .CLK           (CLK),
    .RST           (RST),
    .core_start    (core_start),
    .core_operands (core_operands),
    .core_ready    (core_ready),
    .core_result   (core_result)
  );

endmodule

//--- bench/clock_gen.sv
module clock_gen #(
  parameter int period_ns    = 4,
  parameter int reset_cycles = 10
) (
  output logic CLK,
  output logic RST
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free running clock, low at time 0
  initial begin
    CLK = 1'b0;
    forever #(period_ns / 2) CLK = ~CLK;
  end

  // Reset released just after a rising edge, like other inputs
  initial begin
    RST = 1'b1;
    repeat (reset_cycles) @(posedge CLK);
    #1;
    RST = 1'b0;
  end

endmodule

//--- bench/tb_log_unit.sv
module tb_log_unit;
  timeunit 1ns;
  timeprecision 100ps;
  import log_data_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Run length

  localparam int clk_period_ns = 4;
  localparam int n_exact       = 40;
  localparam int n_reduced     = 24;
  localparam int n_trivial     = 12;
  localparam int n_mixed       = 16;
  localparam int n_single      = 1;
  localparam int n_total       = n_exact + n_reduced + n_trivial + n_mixed + n_single;
  // Worst element takes about 40 cycles
  localparam int watchdog_cycles = n_total * 200 + 500;

  logic     CLK;
  logic     RST;
  logic     start;
  count_t   size_in;
  data_t    data_a_in;
  logic     data_a_in_enable;
  data_t    data_b_in;
  logic     data_b_in_enable;
  data_t    modulo_in;
  data_t    data_out;
  logic     data_out_enable;
  logic     ready;

  // Expected results in issue order
  data_t      expected_mem [0:511];
  logic [8:0] expected_wr;
  logic [8:0] expected_rd;
  data_t      expected_head;

  // Run bookkeeping from the start/ready protocol
  logic   run_active;
  count_t run_size;
  count_t outputs_seen;

  int seed;
  int mismatch_count;
  int protocol_count;
  int missing_count;

  clock_gen #(.period_ns(clk_period_ns), .reset_cycles(10)) clocks (
    .CLK (CLK),
    .RST (RST)
  );

  log_unit_top UUT (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .size_in          (size_in),
    .data_a_in        (data_a_in),
    .data_a_in_enable (data_a_in_enable),
    .data_b_in        (data_b_in),
    .data_b_in_enable (data_b_in_enable),
    .modulo_in        (modulo_in),
    .data_out         (data_out),
    .data_out_enable  (data_out_enable),
    .ready            (ready)
  );

  assign expected_head = expected_mem[expected_rd];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      run_active   <= 1'b0;
      run_size     <= '0;
      outputs_seen <= '0;
      expected_rd  <= '0;
    end else begin
      if (start && !run_active) begin
        run_active   <= 1'b1;
        run_size     <= size_in;
        outputs_seen <= '0;
      end else begin
        if (data_out_enable) begin
          outputs_seen <= outputs_seen + count_t'(1);
        end
        if (ready) begin
          run_active <= 1'b0;
        end
      end
      // Pop the head once it has been compared
      if (data_out_enable) begin
        expected_rd <= expected_rd + 9'd1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks

  // Result against the model
  assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |-> (data_out == expected_head))
  else begin
    mismatch_count++;
    $display("Mismatch at %0t: data_out expected %0d, got %0d",
             $time, $sampled(expected_head), $sampled(data_out));
  end

  // No more outputs than the vector length
  assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |-> (outputs_seen < run_size))
  else begin
    protocol_count++;
    $display("At %0t an output came after all %0d elements were done", $time, run_size);
  end

  // ready only with the last output, or alone for an empty vector
  assert property (@(posedge CLK) disable iff (RST)
    ready |-> ((run_size == '0) ?
               (!data_out_enable && outputs_seen == '0) :
               (data_out_enable && (outputs_seen + count_t'(1)) == run_size)))
  else begin
    protocol_count++;
    $display("At %0t ready came apart from the last output, %0d of %0d outputs seen",
             $time, outputs_seen, run_size);
  end

  // Last output brings ready along
  assert property (@(posedge CLK) disable iff (RST)
    (data_out_enable && (outputs_seen + count_t'(1)) == run_size) |-> ready)
  else begin
    protocol_count++;
    $display("At %0t the last of %0d outputs came without ready", $time, run_size);
  end

  // Quiet outside a run, and after reset until the first start
  assert property (@(posedge CLK) disable iff (RST)
    !run_active |-> (!ready && !data_out_enable))
  else begin
    protocol_count++;
    $display("At %0t ready or data_out_enable rose with no run in progress", $time);
  end

  // Empty vector finishes one cycle after start
  assert property (@(posedge CLK) disable iff (RST)
    (start && !run_active && size_in == '0) |=> (ready && !data_out_enable))
  else begin
    protocol_count++;
    $display("At %0t an empty vector did not give ready alone one cycle after start", $time);
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model and helpers

  // floor(log_b(a)) by repeated division, then the modulus
  function automatic data_t log_model(input data_t a, input data_t b, input data_t m);
    data_t rest;
    data_t n;
    rest = a;
    n = '0;
    if (a != '0 && b >= data_t'(2)) begin
      while (rest >= b) begin
        rest = rest / b;
        n = n + data_t'(1);
      end
    end
    // Modulus 0 leaves the count alone
    if (m != '0) begin
      n = n % m;
    end
    return n;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic data_t rand_word();
    return data_t'($random(seed));
  endfunction

  // Inputs change 1 ns after the rising edge
  task automatic advance_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) advance_cycle();
  endtask

  task automatic begin_vector(input int size);
    start   = 1'b1;
    size_in = count_t'(size);
    advance_cycle();
    start   = 1'b0;
  endtask

  task automatic pulse_operand(input bit is_a, input data_t value);
    if (is_a) begin
      data_a_in        = value;
      data_a_in_enable = 1'b1;
    end else begin
      data_b_in        = value;
      data_b_in_enable = 1'b1;
    end
    advance_cycle();
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
  endtask

  // order 0 together, 1 a first, 2 b first; junk pair lands in await
  task automatic offer_element(input data_t a, input data_t b, input data_t m,
                               input int order, input int gap, input bit junk);
    expected_mem[expected_wr] = log_model(a, b, m);
    expected_wr = expected_wr + 9'd1;
    modulo_in = m;
    case (order)
      0: begin
        data_a_in        = a;
        data_b_in        = b;
        data_a_in_enable = 1'b1;
        data_b_in_enable = 1'b1;
        advance_cycle();
        data_a_in_enable = 1'b0;
        data_b_in_enable = 1'b0;
      end
      1: begin
        pulse_operand(1'b1, a);
        idle_cycles(gap);
        pulse_operand(1'b0, b);
      end
      default: begin
        pulse_operand(1'b0, b);
        idle_cycles(gap);
        pulse_operand(1'b1, a);
      end
    endcase
    if (junk) begin
      data_a_in        = ~a;
      data_b_in        = data_t'(2);
      modulo_in        = data_t'(1);
      data_a_in_enable = 1'b1;
      data_b_in_enable = 1'b1;
      advance_cycle();
      data_a_in_enable = 1'b0;
      data_b_in_enable = 1'b0;
    end
    // Wait out the variable core latency
    while (data_out_enable !== 1'b1) begin
      advance_cycle();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    data_t a;
    data_t b;
    start            = 1'b0;
    size_in          = '0;
    data_a_in        = '0;
    data_a_in_enable = 1'b0;
    data_b_in        = '0;
    data_b_in_enable = 1'b0;
    modulo_in        = '0;
    expected_wr      = '0;
    seed             = 80692;
    mismatch_count   = 0;
    protocol_count   = 0;
    missing_count    = 0;
    @(negedge RST);
    idle_cycles(4);

    // Exact floor logarithm over a spread of magnitudes
    begin_vector(n_exact);
    for (int i = 0; i < n_exact; i++) begin
      a = rand_word() >> rand_range(0, 15);
      offer_element(a, data_t'(rand_range(2, 16)), '0, 0, 0, 1'b0);
    end
    idle_cycles(3);

    // Log of at least 4, modulus 1 to 3
    begin_vector(n_reduced);
    for (int i = 0; i < n_reduced; i++) begin
      a = rand_word() | data_t'(16'h0100);
      offer_element(a, data_t'(rand_range(2, 4)), data_t'(rand_range(1, 3)), 0, 0, 1'b0);
    end
    idle_cycles(3);

    // Zero argument, base 0, base 1
    begin_vector(n_trivial);
    for (int i = 0; i < n_trivial; i++) begin
      a = (i % 3 == 0) ? '0 : rand_word();
      b = (i % 3 == 0) ? data_t'(rand_range(0, 16)) : data_t'(i % 3 - 1);
      offer_element(a, b, data_t'(rand_range(0, 3)), rand_range(0, 2), 0, 1'b0);
    end
    idle_cycles(3);

    // Either order, gaps between operands, junk while busy
    begin_vector(n_mixed);
    for (int i = 0; i < n_mixed; i++) begin
      offer_element(rand_word(), data_t'(rand_range(2, 16)), data_t'(rand_range(0, 7)),
                    rand_range(0, 2), rand_range(0, 4), i[0]);
    end
    idle_cycles(3);

    // Empty vector, then a one element vector
    begin_vector(0);
    while (ready !== 1'b1) begin
      advance_cycle();
    end
    idle_cycles(3);
    begin_vector(n_single);
    offer_element(data_t'(1000), data_t'(10), '0, 2, 3, 1'b1);
    idle_cycles(5);

    if (expected_rd != expected_wr) begin
      missing_count = int'(expected_wr - expected_rd);
      $display("%0d expected outputs never arrived", missing_count);
    end
    $display("Errors: %0d mismatch, %0d protocol, %0d missing",
             mismatch_count, protocol_count, missing_count);
    if (mismatch_count + protocol_count + missing_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Watchdog

  initial begin
    #(watchdog_cycles * clk_period_ns);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("Errors: %0d mismatch, %0d protocol, %0d missing",
             mismatch_count, protocol_count, missing_count);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- compile.f
hdl/log_data_pkg.sv
hdl/log_ctrl_pkg.sv
hdl/modulo_reduce.sv
hdl/scalar_logarithm.sv
hdl/vector_logarithm.sv
hdl/log_unit_top.sv
bench/clock_gen.sv
bench/tb_log_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the log unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module tb_log_unit \
  --Mdir "$build_dir" -o sim_log_unit \
  -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/sim_log_unit" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

# The verdict comes from the log
if grep -q '^>>> PASS$' "$log_file"; then
  exit 0
fi
echo "Pass message not found in $log_file"
exit 1
